/* filelist.f */
hdl/dcache_pkg.sv
hdl/miss_if.sv
hdl/store_merge.sv
hdl/miss_entry.sv
hdl/dcache_ctrl.sv
hdl/fill_unit.sv
hdl/dcache_top.sv
testbench/tb_memory.sv
testbench/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the data cache testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module dcache_tb -f filelist.f -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/dcache_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

/* testbench/dcache_tb.sv */
/*
 * testbench for the data cache
 * directed miss, store, eviction and retry cases, then a random mix, all against a golden memory
 */
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int directed_requests = 68;
    localparam int random_requests   = 400;
    localparam int cycle_limit       = 200 * (directed_requests + random_requests) + 1000;

    logic                    clk = 1'b0;
    logic                    reset;
    bus_cmd_t                req_cmd;
    logic [addr_bits-1:0]    req_addr;
    mem_size_t               req_size;
    logic [63:0]             req_wdata;
    logic [mem_tag_bits-1:0] resp_tag;
    logic                    hit;
    logic [63:0]             rdata;
    logic [mem_tag_bits-1:0] data_tag;
    bus_cmd_t                mem_cmd;
    logic [addr_bits-1:0]    mem_addr;
    logic [63:0]             mem_wdata;
    logic [mem_tag_bits-1:0] mem_response;
    logic [63:0]             mem_rdata;
    logic [mem_tag_bits-1:0] mem_tag;
    logic                    hold_off;

    logic [63:0]    golden [512];    // line contents as the processor should see them
    logic [63:0]    exp_line [16];   // expected fill line per outstanding tag
    logic [15:0]    pending = '0;
    logic [63:0]    expected_line;
    bus_cmd_t       last_cmd;        // request that got the latest answer
    logic [31:0]    last_addr;
    mem_size_t      last_size;
    logic [63:0]    last_wdata;
    logic           got_hit;
    int             waited;
    int             hold_until = 0;
    int             cycles = 0;
    int             errors = 0;
    int             checks = 0;
    int             accepted = 0;
    int             completed = 0;
    int             seed;
    int             rnd;
    int             k;
    int             n;
    int             sz;
    int             off;
    logic [31:0]    addr;
    logic [31:0]    evict_addr;
    mem_size_t      size;
    logic [63:0]    wdata;

    assign hold_off = cycles < hold_until;

    dcache_top i_dut (
        .clk, .reset,
        .req_cmd, .req_addr, .req_size, .req_wdata,
        .resp_tag, .hit, .rdata, .data_tag,
        .mem_cmd, .mem_addr, .mem_wdata,
        .mem_response, .mem_rdata, .mem_tag
    );

    tb_memory i_mem (
        .clk, .reset, .hold_off,
        .mem_cmd, .mem_addr, .mem_wdata,
        .mem_response, .mem_rdata, .mem_tag
    );

    always #5 clk = ~clk;

    // store bytes placed lane by lane, lowest byte of data at the offset
    function automatic logic [63:0] merge_ref(input logic [63:0] line, input logic [63:0] data,
                                              input logic [2:0] offset, input mem_size_t sz_in);
        cache_line_u u;
        int          lanes;
        int          i;
        u     = line;
        lanes = 1 << int'(sz_in);
        for (i = 0; i < lanes; i++) begin
            u.bytes[int'(offset) + i] = data[8*i +: 8];
        end
        return u;
    endfunction

    function automatic logic [2:0] align_offset(input logic [2:0] offset, input mem_size_t sz_in);
        case (sz_in)
            size_byte: return offset;
            size_half: return {offset[2:1], 1'b0};
            size_word: return {offset[2], 2'b00};
            default:   return 3'd0;
        endcase
    endfunction

    function automatic logic [31:0] make_addr(input int line_tag, input int index, input int offset);
        return 32'((line_tag << 9) | (index << 3) | offset);
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("t=%0t %s", $time, msg);
    endtask

    // golden line after the answered request, store applied
    task automatic apply_request(output logic [63:0] line);
        line = golden[last_addr[11:3]];
        if (last_cmd == bus_store) begin
            line = merge_ref(line, last_wdata, last_addr[2:0], last_size);
            golden[last_addr[11:3]] = line;
        end
    endtask

    // hold the request until a hit or a response tag, retries included
    task automatic issue(input bus_cmd_t cmd, input logic [31:0] a, input mem_size_t s,
                         input logic [63:0] d);
        req_cmd   = cmd;
        req_addr  = a;
        req_size  = s;
        req_wdata = d;
        waited    = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!hit && resp_tag == '0);
        got_hit    = hit;
        last_cmd   = cmd; // read by the compare process on the next rising edge
        last_addr  = a;
        last_size  = s;
        last_wdata = d;
        req_cmd    = bus_none;
    endtask

    task automatic drain();
        @(negedge clk);
        while (pending != '0) begin
            @(negedge clk);
        end
    endtask

    // answers are registered, so the rising edge still sees this cycle's values
    always @(posedge clk) begin
        if (!reset) begin
            if (data_tag != '0) begin
                if (!pending[data_tag]) begin
                    report_problem($sformatf("data_tag %0d came back with no miss outstanding",
                                             data_tag));
                end else begin
                    check_value("rdata on data_tag", exp_line[data_tag], rdata);
                    pending[data_tag] = 1'b0;
                    completed++;
                end
            end
            if (hit) begin
                apply_request(expected_line);
                check_value("rdata on hit", expected_line, rdata);
            end
            if (resp_tag != '0) begin
                if (pending[resp_tag]) begin
                    report_problem($sformatf("resp_tag %0d handed out twice", resp_tag));
                end
                apply_request(expected_line);
                exp_line[resp_tag] = expected_line; // no other request reaches this line meanwhile
                pending[resp_tag]  = 1'b1;
                accepted++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        seed      = 84;
        reset     = 1'b1;
        req_cmd   = bus_none;
        req_addr  = '0;
        req_size  = size_byte;
        req_wdata = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (k = 0; k < 512; k++) begin
            golden[k] = i_mem.mem[k];
        end
        check_value("hit after reset", 64'd0, 64'(hit));
        check_value("resp_tag after reset", 64'd0, 64'(resp_tag));
        check_value("data_tag after reset", 64'd0, 64'(data_tag));
        check_value("mem_cmd after reset", 64'd0, 64'(mem_cmd));

        // load miss, then the same line again right away
        addr = make_addr(4, 0, 0);
        issue(bus_load, addr, size_double, 64'd0);
        check_value("hit on first load", 64'd0, 64'(got_hit));
        issue(bus_load, addr, size_double, 64'd0);
        check_value("hit on repeat load", 64'd1, 64'(got_hit));
        drain();

        // every size at every legal offset, hit line at index 1, misses alternate at index 2
        issue(bus_load, make_addr(5, 1, 0), size_double, 64'd0);
        n = 0;
        for (sz = 0; sz < 4; sz++) begin
            for (off = 0; off < 8; off += 1 << sz) begin
                size  = mem_size_t'(2'(sz));
                wdata = {$random(seed), $random(seed)};
                addr  = make_addr(5, 1, off);
                issue(bus_store, addr, size, wdata);
                issue(bus_load, addr, size_double, 64'd0);
                addr = make_addr(6 + n % 2, 2, off); // other tag evicts the dirty line
                issue(bus_store, addr, size, wdata);
                issue(bus_load, addr, size_double, 64'd0);
                n++;
            end
        end
        drain();

        // dirty line evicted by a load at the same index, then reloaded from memory
        evict_addr = make_addr(4, 3, 0);
        issue(bus_store, evict_addr, size_double, {$random(seed), $random(seed)});
        drain();
        issue(bus_load, make_addr(5, 3, 0), size_double, 64'd0);
        drain();
        issue(bus_load, evict_addr, size_double, 64'd0);
        drain();

        // memory withholds its response, then a second request waits on the miss
        addr       = make_addr(4, 4, 0);
        hold_until = cycles + 12;
        issue(bus_load, addr, size_double, 64'd0);
        if (waited < 12) begin
            report_problem("load answered while memory withheld its response");
        end
        issue(bus_load, addr, size_double, 64'd0);
        check_value("hit after outstanding miss", 64'd1, 64'(got_hit));
        drain();

        // random mix over 4 tags at indexes 8 to 15
        for (n = 0; n < random_requests; n++) begin
            rnd   = $random(seed);
            size  = mem_size_t'(rnd[1:0]);
            off   = int'(align_offset(rnd[9:7], size));
            addr  = make_addr(int'(rnd[3:2]), 8 + int'(rnd[6:4]), off);
            wdata = {$random(seed), $random(seed)};
            issue(rnd[10] ? bus_store : bus_load, addr, size, wdata);
        end
        drain();

        check_value("written-back line in memory", golden[evict_addr[11:3]],
                    i_mem.mem[evict_addr[11:3]]);
        check_value("misses completed", 64'(accepted), 64'(completed));
        $display("errors %0d, checks %0d, misses accepted %0d, completed %0d",
                 errors, checks, accepted, completed);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* testbench/tb_memory.sv */
/*
 * tagged memory model for the data cache testbench
 * hands out free tags with random stalls, returns lines out of order, applies stores at once
 */
`timescale 1ns/1ps

module tb_memory (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                hold_off,     // withhold every load response
    input  dcache_pkg::bus_cmd_t                mem_cmd,
    input  logic [dcache_pkg::addr_bits-1:0]    mem_addr,
    input  logic [63:0]                         mem_wdata,
    output logic [dcache_pkg::mem_tag_bits-1:0] mem_response,
    output logic [63:0]                         mem_rdata,
    output logic [dcache_pkg::mem_tag_bits-1:0] mem_tag
);
    import dcache_pkg::*;

    logic [63:0] mem [512];    // 4 KB of 8-byte lines
    logic [8:0]  line_of [16]; // line number held by each tag
    int          due [16];     // first cycle on which the tag may return
    logic [15:0] busy;
    int          now;
    int          seed;
    int          start;
    int          k;
    int          t;

    initial begin
        seed         = 84;
        now          = 0;
        busy         = '0;
        mem_response = '0;
        mem_rdata    = '0;
        mem_tag      = '0;
        for (k = 0; k < 512; k++) begin
            mem[k] = {32'(k) * 32'h9e37_79b1, 32'(k) ^ 32'hc3a5_0f1e}; // unique per line
        end
    end

    // sampled before the DUT flops update
    always @(posedge clk) begin
        now = now + 1;
        if (!reset) begin
            if (mem_cmd == bus_store) begin
                mem[mem_addr[11:3]] = mem_wdata; // write-back lands at once
            end
            if (mem_cmd == bus_load && mem_response != '0) begin
                busy[mem_response]    = 1'b1;
                line_of[mem_response] = mem_addr[11:3];
                due[mem_response]     = now + 1 + int'({$random(seed)} % 19); // 2 to 20 cycles
            end
            if (mem_tag != '0) begin
                busy[mem_tag] = 1'b0; // tag free again from the next cycle
            end
        end
    end

    always @(negedge clk) begin
        mem_response = '0;
        mem_tag      = '0;
        if (!reset) begin
            // random stall, otherwise the first free tag after a random start
            if (mem_cmd == bus_load && !hold_off && ({$random(seed)} % 4) != 0) begin
                start = int'({$random(seed)} % 15);
                for (t = 0; t < 15; t++) begin
                    if (mem_response == '0 && !busy[(start + t) % 15 + 1]) begin
                        mem_response = 4'((start + t) % 15 + 1);
                    end
                end
            end
            for (t = 1; t < 16; t++) begin // one return per cycle
                if (mem_tag == '0 && busy[t] && now >= due[t]) begin
                    mem_tag   = 4'(t);
                    mem_rdata = mem[line_of[t]];
                end
            end
        end
    end

endmodule

/* hdl/dcache_top.sv */
/*
 * data cache top level with plain processor and memory ports
 * wires the controller, the fill unit and fifteen miss entries
 */
`timescale 1ns/1ps

module dcache_top (
    input  logic                                clk,
    input  logic                                reset,
    input  dcache_pkg::bus_cmd_t                req_cmd,
    input  logic [dcache_pkg::addr_bits-1:0]    req_addr,
    input  dcache_pkg::mem_size_t               req_size,
    input  logic [63:0]                         req_wdata,
    output logic [dcache_pkg::mem_tag_bits-1:0] resp_tag,
    output logic                                hit,
    output logic [63:0]                         rdata,
    output logic [dcache_pkg::mem_tag_bits-1:0] data_tag,
    output dcache_pkg::bus_cmd_t                mem_cmd,
    output logic [dcache_pkg::addr_bits-1:0]    mem_addr,
    output logic [63:0]                         mem_wdata,
    input  logic [dcache_pkg::mem_tag_bits-1:0] mem_response,
    input  logic [63:0]                         mem_rdata,
    input  logic [dcache_pkg::mem_tag_bits-1:0] mem_tag
);
    import dcache_pkg::*;

    bus_cmd_t                ld_cmd;
    logic [addr_bits-1:0]    ld_addr;
    logic [mem_tag_bits-1:0] alloc_tag;
    logic [addr_bits-1:0]    cap_addr;
    mem_size_t               cap_size;
    logic [63:0]             cap_wdata;
    logic                    cap_is_store;
    logic                    fill_valid;
    logic [index_bits-1:0]   fill_index;
    logic [tag_bits-1:0]     fill_tag;
    logic [63:0]             fill_line;
    logic                    fill_dirty;
    logic [mem_tag_bits-1:0] fill_tag_out;
    logic [tag_bits-1:0]     victim_tag;
    logic [63:0]             victim_line;
    logic                    victim_valid;
    logic                    victim_dirty;
    logic                    wb_pending;
    logic [addr_bits-1:0]    wb_addr;
    logic [63:0]             wb_data;

    miss_if entry_bus [num_entries] ();

    dcache_ctrl i_ctrl (
        .clk, .reset,
        .req_cmd, .req_addr, .req_size, .req_wdata,
        .resp_tag, .hit, .rdata, .data_tag,
        .mem_response,
        .ld_cmd, .ld_addr, .alloc_tag,
        .cap_addr, .cap_size, .cap_wdata, .cap_is_store,
        .entries (entry_bus),
        .fill_valid, .fill_index, .fill_tag, .fill_line, .fill_dirty, .fill_tag_out,
        .victim_tag, .victim_line, .victim_valid, .victim_dirty,
        .wb_pending
    );

    fill_unit i_fill (
        .clk, .reset,
        .mem_tag, .mem_rdata,
        .entries (entry_bus),
        .victim_tag, .victim_line, .victim_valid, .victim_dirty,
        .fill_valid, .fill_index, .fill_tag, .fill_line, .fill_dirty, .fill_tag_out,
        .wb_pending, .wb_addr, .wb_data
    );

    // entry g answers to memory tag g+1
    for (genvar g = 0; g < num_entries; g++) begin : g_entry
        miss_entry #(.entry_tag(g + 1)) i_entry (
            .clk, .reset, .alloc_tag,
            .req_addr     (cap_addr),
            .req_size     (cap_size),
            .req_wdata    (cap_wdata),
            .req_is_store (cap_is_store),
            .probe_addr   (req_addr), // in-flight check for the live request
            .port         (entry_bus[g])
        );
    end

    // write-back store beats the load for the memory port
    assign mem_cmd   = wb_pending ? bus_store : ld_cmd;
    assign mem_addr  = wb_pending ? wb_addr : ld_addr;
    assign mem_wdata = wb_pending ? wb_data : '0;

endmodule

/* hdl/fill_unit.sv */
/*
 * retires the miss entry named by the returning memory tag
 * builds the installed line and registers a dirty victim for one write-back cycle
 */
`timescale 1ns/1ps

module fill_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [dcache_pkg::mem_tag_bits-1:0] mem_tag,
    input  logic [63:0]                         mem_rdata,
    miss_if.fill                                entries [dcache_pkg::num_entries],
    input  logic [dcache_pkg::tag_bits-1:0]     victim_tag,
    input  logic [63:0]                         victim_line,
    input  logic                                victim_valid,
    input  logic                                victim_dirty,
    output logic                                fill_valid,
    output logic [dcache_pkg::index_bits-1:0]   fill_index,
    output logic [dcache_pkg::tag_bits-1:0]     fill_tag,
    output logic [63:0]                         fill_line,
    output logic                                fill_dirty,
    output logic [dcache_pkg::mem_tag_bits-1:0] fill_tag_out,
    output logic                                wb_pending,
    output logic [dcache_pkg::addr_bits-1:0]    wb_addr,
    output logic [63:0]                         wb_data
);
    import dcache_pkg::*;

    logic [num_entries-1:0] e_valid;
    logic [num_entries-1:0] e_store;
    logic [addr_bits-1:0]   e_addr  [num_entries];
    mem_size_t              e_size  [num_entries];
    logic [63:0]            e_wdata [num_entries];
    logic [mem_tag_bits-1:0] sel;
    logic [addr_bits-1:0]   sel_addr;
    logic [63:0]            merged;

    for (genvar g = 0; g < num_entries; g++) begin : g_sel
        assign e_valid[g]       = entries[g].valid;
        assign e_store[g]       = entries[g].is_store;
        assign e_addr[g]        = entries[g].addr;
        assign e_size[g]        = entries[g].size;
        assign e_wdata[g]       = entries[g].wdata;
        assign entries[g].clear = fill_valid && (mem_tag == mem_tag_bits'(g + 1));
    end

    // tags start at 1, entry 0 holds tag 1
    assign sel        = (mem_tag == '0) ? '0 : mem_tag - 1'b1;
    assign sel_addr   = e_addr[sel];
    assign fill_valid = (mem_tag != '0) && e_valid[sel];
    assign fill_index = sel_addr[offset_bits +: index_bits];
    assign fill_tag   = sel_addr[addr_bits-1 -: tag_bits];

    store_merge i_fill_merge (
        .line_in    (mem_rdata),
        .store_data (e_wdata[sel]),
        .offset     (sel_addr[offset_bits-1:0]),
        .size       (e_size[sel]),
        .line_out   (merged)
    );

    assign fill_line    = e_store[sel] ? merged : mem_rdata; // store miss lands dirty
    assign fill_dirty   = e_store[sel];
    assign fill_tag_out = fill_valid ? mem_tag : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_pending <= 1'b0;
        end else begin
            wb_pending <= fill_valid && victim_valid && victim_dirty;
        end
    end

    // victim address rebuilt from its old tag and the shared index
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            wb_addr <= {victim_tag, fill_index, {offset_bits{1'b0}}};
            wb_data <= victim_line;
        end
    end

endmodule

/* hdl/dcache_ctrl.sv */
/*
 * line arrays, hit detection and the idle/miss FSM
 * presents one load at a time and installs lines handed over by the fill unit
 */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                clk,
    input  logic                                reset,
    input  dcache_pkg::bus_cmd_t                req_cmd,
    input  logic [dcache_pkg::addr_bits-1:0]    req_addr,
    input  dcache_pkg::mem_size_t               req_size,
    input  logic [63:0]                         req_wdata,
    output logic [dcache_pkg::mem_tag_bits-1:0] resp_tag,
    output logic                                hit,
    output logic [63:0]                         rdata,
    output logic [dcache_pkg::mem_tag_bits-1:0] data_tag,
    input  logic [dcache_pkg::mem_tag_bits-1:0] mem_response,
    output dcache_pkg::bus_cmd_t                ld_cmd,
    output logic [dcache_pkg::addr_bits-1:0]    ld_addr,
    output logic [dcache_pkg::mem_tag_bits-1:0] alloc_tag,
    output logic [dcache_pkg::addr_bits-1:0]    cap_addr,
    output dcache_pkg::mem_size_t               cap_size,
    output logic [63:0]                         cap_wdata,
    output logic                                cap_is_store,
    miss_if.ctrl                                entries [dcache_pkg::num_entries],
    input  logic                                fill_valid,
    input  logic [dcache_pkg::index_bits-1:0]   fill_index,
    input  logic [dcache_pkg::tag_bits-1:0]     fill_tag,
    input  logic [63:0]                         fill_line,
    input  logic                                fill_dirty,
    input  logic [dcache_pkg::mem_tag_bits-1:0] fill_tag_out,
    output logic [dcache_pkg::tag_bits-1:0]     victim_tag,
    output logic [63:0]                         victim_line,
    output logic                                victim_valid,
    output logic                                victim_dirty,
    input  logic                                wb_pending
);
    import dcache_pkg::*;

    logic [63:0]          data_arr [num_lines];
    logic [tag_bits-1:0]  tag_arr  [num_lines];
    logic [num_lines-1:0] valid_arr;
    logic [num_lines-1:0] dirty_arr;

    logic                   miss_state; // 0 idle, 1 waiting for the load to be accepted
    logic [tag_bits-1:0]    req_tag;
    logic [index_bits-1:0]  req_index;
    logic [index_bits-1:0]  cap_index;  // line slot of the held miss
    logic [tag_bits-1:0]    cap_tag;
    logic [num_entries-1:0] match_vec;
    logic [num_entries-1:0] busy_vec;
    logic                   busy;
    logic                   lookup_hit;
    logic                   go;
    logic                   accept;
    logic [63:0]            merged;
    logic [63:0]            hit_line;

    assign req_tag   = req_addr[addr_bits-1 -: tag_bits];
    assign req_index = req_addr[offset_bits +: index_bits];
    assign cap_index = cap_addr[offset_bits +: index_bits];
    assign cap_tag   = cap_addr[addr_bits-1 -: tag_bits];

    for (genvar g = 0; g < num_entries; g++) begin : g_probe
        assign match_vec[g] = entries[g].line_match;
        assign busy_vec[g]  = entries[g].valid;
    end

    // retry on a returning fill, a pending write-back or a line already in flight
    assign busy       = fill_valid || wb_pending || (|(match_vec & busy_vec));
    assign lookup_hit = valid_arr[req_index] && (tag_arr[req_index] == req_tag);
    assign go         = !miss_state && (req_cmd != bus_none) && !busy;

    store_merge i_hit_merge (
        .line_in    (data_arr[req_index]),
        .store_data (req_wdata),
        .offset     (req_addr[offset_bits-1:0]),
        .size       (req_size),
        .line_out   (merged)
    );

    assign hit_line = (req_cmd == bus_store) ? merged : data_arr[req_index];

    // load waits out the write-back cycle, which owns the memory port
    assign ld_cmd    = (miss_state && !wb_pending) ? bus_load : bus_none;
    assign ld_addr   = {cap_addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
    assign accept    = miss_state && !wb_pending && (mem_response != '0);
    assign alloc_tag = accept ? mem_response : '0;

    // line about to be displaced by the fill
    assign victim_tag   = tag_arr[fill_index];
    assign victim_line  = data_arr[fill_index];
    assign victim_valid = valid_arr[fill_index];
    assign victim_dirty = dirty_arr[fill_index];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            miss_state <= 1'b0;
            hit        <= 1'b0;
            resp_tag   <= '0;
            data_tag   <= '0;
            valid_arr  <= '0;
            dirty_arr  <= '0;
        end else begin
            hit      <= go && lookup_hit;
            resp_tag <= accept ? mem_response : '0; // tag answer for the held miss
            data_tag <= fill_valid ? fill_tag_out : '0;
            if (go && !lookup_hit) begin
                miss_state <= 1'b1;
            end else if (accept) begin
                miss_state <= 1'b0;
            end
            if (fill_valid) begin
                valid_arr[fill_index] <= 1'b1;
                dirty_arr[fill_index] <= fill_dirty;
            end else if (go && lookup_hit && req_cmd == bus_store) begin
                dirty_arr[req_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            data_arr[fill_index] <= fill_line;
            tag_arr[fill_index]  <= fill_tag;
            rdata                <= fill_line; // returned with data_tag
        end else if (go && lookup_hit) begin
            rdata <= hit_line;
            if (req_cmd == bus_store) begin
                data_arr[req_index] <= merged;
            end
        end
        if (go && !lookup_hit) begin // capture the miss for the entries
            cap_addr     <= req_addr;
            cap_size     <= req_size;
            cap_wdata    <= req_wdata;
            cap_is_store <= (req_cmd == bus_store);
        end
    end

    // a presented load is for a line the arrays do not hold yet
    a_load_for_miss: assert property (@(posedge clk) disable iff (reset)
        ld_cmd == bus_load |-> !(valid_arr[cap_index] && tag_arr[cap_index] == cap_tag));

endmodule

/* hdl/miss_entry.sv */
/*
 * one outstanding-miss record bound to a fixed memory tag
 * loads the captured request when the controller allocates its tag
 */
`timescale 1ns/1ps

module miss_entry #(
    parameter int entry_tag = 1
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [dcache_pkg::mem_tag_bits-1:0] alloc_tag,
    input  logic [dcache_pkg::addr_bits-1:0]  req_addr,
    input  dcache_pkg::mem_size_t             req_size,
    input  logic [63:0]                       req_wdata,
    input  logic                              req_is_store,
    input  logic [dcache_pkg::addr_bits-1:0]  probe_addr,
    miss_if.entry                             port
);
    import dcache_pkg::*;

    logic alloc;

    assign alloc = (alloc_tag == mem_tag_bits'(entry_tag));

    // a new allocation wins over a clear of the previous owner
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            port.valid <= 1'b0;
        end else if (alloc) begin
            port.valid <= 1'b1;
        end else if (port.clear) begin
            port.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            port.addr     <= req_addr;
            port.size     <= req_size;
            port.wdata    <= req_wdata;
            port.is_store <= req_is_store;
        end
    end

    // same line, offset ignored
    assign port.line_match = port.valid &&
        (port.addr[addr_bits-1:offset_bits] == probe_addr[addr_bits-1:offset_bits]);

    // memory must not reissue a tag whose data has not come back
    a_no_realloc: assert property (@(posedge clk) disable iff (reset)
        alloc |-> !port.valid || port.clear);

endmodule

/* hdl/store_merge.sv */
/*
 * writes the bytes of a store into a 64-bit line
 * pure combinational, used for store hits and for store miss fills
 */
`timescale 1ns/1ps

module store_merge (
    input  logic [63:0]           line_in,
    input  logic [63:0]           store_data,
    input  logic [2:0]            offset,
    input  dcache_pkg::mem_size_t size,
    output logic [63:0]           line_out
);
    import dcache_pkg::*;

    cache_line_u line;

    always_comb begin
        line = line_in;
        case (size)
            size_byte: line.bytes[offset] = store_data[7:0];
            size_half: line.halves[offset[2:1]] = store_data[15:0]; // low offset bit dropped
            size_word: line.words[offset[2]] = store_data[31:0];
            default:   line = store_data; // double covers the whole line
        endcase
        line_out = line;
    end

    // halves sit on even bytes and words on 4-byte boundaries
    always_comb begin
        if (size == size_half) begin
            assert (offset[0] == 1'b0) else $error("misaligned half store");
        end
        if (size == size_word) begin
            assert (offset[1:0] == 2'b00) else $error("misaligned word store");
        end
    end

endmodule

/* hdl/miss_if.sv */
/*
 * contents of one outstanding miss
 * the entry owns the record, the controller probes it, the fill unit retires it
 */
`timescale 1ns/1ps

interface miss_if;
    import dcache_pkg::*;

    logic                 valid;      // record holds a live miss
    logic [addr_bits-1:0] addr;       // full request address
    mem_size_t            size;
    logic [63:0]          wdata;      // store data, unused for loads
    logic                 is_store;
    logic                 line_match; // probe address hits this record's line
    logic                 clear;      // fill unit retires the record

    modport ctrl (input valid, input line_match);

    modport entry (
        output valid,
        output addr,
        output size,
        output wdata,
        output is_store,
        output line_match,
        input  clear
    );

    modport fill (input valid, input addr, input size, input wdata, input is_store,
                  output clear);

endinterface

/* hdl/dcache_pkg.sv */
/*
 * shared widths, bus codes and the line view used by the data cache
 * every cache file imports this package
 */
package dcache_pkg;

    // address split for 64 lines of 8 bytes
    localparam int addr_bits   = 32;
    localparam int tag_bits    = 23;
    localparam int index_bits  = 6;
    localparam int offset_bits = 3;
    localparam int num_lines   = 64;

    // memory transaction tags, 0 means no transaction
    localparam int mem_tag_bits = 4;
    localparam int num_entries  = 15;

    // command on the processor and memory sides
    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_cmd_t;

    // access width of a request
    typedef enum logic [1:0] {
        size_byte   = 2'd0,
        size_half   = 2'd1,
        size_word   = 2'd2,
        size_double = 2'd3
    } mem_size_t;

    // one cache line seen as bytes, halves or words
    typedef union packed {
        logic [7:0][7:0]  bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
    } cache_line_u;

endpackage
